/* Makefile */
# Verilator build and run for the counter_display testbench

VERILATOR   ?= verilator
TOP         ?= counter_display_tb
FILELIST    ?= verilog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing --assert
ERROR_LIMIT ?= 1000
PASS_MSG    := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS ERROR_LIMIT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* include/ttl_params.svh */
`ifndef TTL_PARAMS_SVH
`define TTL_PARAMS_SVH

// number of cascaded SN74192 decade counters
// each digit brings its own SN7447 decoder, 1 to 8 digits supported
`define NUM_DIGITS 3

// shortest level, in CLK_DRV cycles, for up, down, clr, load_n and lt_n
// the registered BCD term inside each counter needs one cycle to settle
`define MIN_PULSE 2

`endif

/* source/counter_display.sv */
`default_nettype none

`include "ttl_params.svh"

module counter_display (
  input  logic                     CLK_DRV,
  input  logic                     rst_n,
  input  logic                     up,       // count up pulse for the units digit
  input  logic                     down,     // count down pulse for the units digit
  input  logic                     clr,
  input  logic                     load_n,
  input  logic                     lt_n,
  input  logic [4*`NUM_DIGITS-1:0] data,     // BCD load value, units in bits 3:0
  output logic [4*`NUM_DIGITS-1:0] count,
  output logic [7*`NUM_DIGITS-1:0] seg,      // 7 bits per digit, units lowest
  output logic                     bo_n,     // borrow of the top digit
  output logic                     co_n      // carry of the top digit
);
  import ttl_pkg::*;

  digit_array_t           digits;            // counter outputs
  digit_array_t           load_digits;       // data cut into digits
  logic [`NUM_DIGITS:0]   up_chain;          // up into digit i, carry out at the end
  logic [`NUM_DIGITS:0]   down_chain;        // down into digit i, borrow out at the end
  logic [`NUM_DIGITS-1:0] rbi_n;             // ripple blanking into each decoder

  assign load_digits   = data;
  assign up_chain[0]   = up;
  assign down_chain[0] = down;

  assign count = digits;
  assign co_n  = up_chain[`NUM_DIGITS];
  assign bo_n  = down_chain[`NUM_DIGITS];

  for (genvar i = 0; i < `NUM_DIGITS; i++) begin : g_digit

    // carry and borrow clock the next digit up, as on the datasheet
    sn74192 i_sn74192 (
      .CLK_DRV,
      .rst_n,
      .up     (up_chain[i]),
      .down   (down_chain[i]),
      .clr,
      .load_n,
      .data   (load_digits[i]),
      .q      (digits[i]),
      .bo_n   (down_chain[i+1]),
      .co_n   (up_chain[i+1])
    );

    // blanking starts at the top digit and ripples toward the units
    // middle digits take rbi_n from the decoder above them
    if (i == 0) begin : g_units
      assign rbi_n[i] = 1'b1;                // units digit always shows
    end else if (i == `NUM_DIGITS-1) begin : g_top
      assign rbi_n[i] = 1'b0;                // leading zero blanks
    end

    // the units digit ignores blanking
    // so digits 0 and 1 have no rbo_n load
    if (i >= 2) begin : g_rb
      sn7447 i_sn7447 (
        .digit  (digits[i]),
        .lt_n,
        .rbi_n  (rbi_n[i]),
        .seg    (seg[7*i +: 7]),
        .rbo_n  (rbi_n[i-1])
      );
    end else begin : g_no_rb
      sn7447 i_sn7447 (
        .digit  (digits[i]),
        .lt_n,
        .rbi_n  (rbi_n[i]),
        .seg    (seg[7*i +: 7]),
        .rbo_n  ()
      );
    end

  end

endmodule

`default_nettype wire

/* source/sn74192.sv */
`default_nettype none

module sn74192 (
  input  logic          CLK_DRV,
  input  logic          rst_n,
  input  logic          up,       // counts on rising edge
  input  logic          down,     // counts on rising edge
  input  logic          clr,      // active high, beats load
  input  logic          load_n,
  input  ttl_pkg::bcd_t data,     // parallel load value
  output ttl_pkg::bcd_t q,
  output logic          bo_n,     // borrow, low while down low at 0
  output logic          co_n      // carry, low while up low at 9
);

  logic       up_n;
  logic       down_n;
  logic       load;
  logic       clr_n;
  logic [3:0] q_n;                // inverted flip-flop outputs
  logic [3:0] ff_clk_n;           // per bit toggle clock
  logic [3:0] ff_pre_n;           // per bit preset from load
  logic [3:0] ff_clr_n;           // per bit clear from load or clr
  logic       bcd;                // any of bits 3 to 1 set
  logic       bcd_q;

  assign up_n   = ~up;
  assign down_n = ~down;
  assign load   = ~load_n;
  assign clr_n  = ~clr;

  assign bcd = ~(q_n[1] & q_n[2] & q_n[3]);

  // the down terms of bits 1 and 2 read q through bcd
  // registering it cuts the loop back into the flip-flops
  always_ff @(posedge CLK_DRV) begin
    if (!rst_n) begin
      bcd_q <= 1'b0;
    end else begin
      bcd_q <= bcd;
    end
  end

  // gate terms of the datasheet logic diagram
  // a term is high while its count pulse is low and falls when the pulse ends
  assign ff_clk_n[0] = down_n | up_n;                        // bit 0 moves on every count
  assign ff_clk_n[1] = (down_n & q_n[0] & bcd_q)
                     | (up_n & q[0] & q_n[3]);               // no carry into bit 1 from 9
  assign ff_clk_n[2] = (down_n & q_n[0] & q_n[1] & bcd_q)
                     | (up_n & q[0] & q[1]);
  assign ff_clk_n[3] = (down_n & q_n[0] & q_n[1] & q_n[2])   // 0 to 9 and 8 to 7
                     | (up_n & q[0] & q[1] & q[2])           // 7 to 8
                     | (up_n & q[0] & q[3]);                 // 9 to 0

  // load sets each bit from data, clr clears all four
  assign ff_pre_n = ~(data & {4{load & clr_n}});
  assign ff_clr_n = {4{clr_n}} & ~(ff_pre_n & {4{load}});

  for (genvar b = 0; b < 4; b++) begin : g_bit
    toggle_ff i_toggle_ff (
      .CLK_DRV,
      .rst_n,
      .clk_n (ff_clk_n[b]),
      .pre_n (ff_pre_n[b]),
      .clr_n (ff_clr_n[b]),
      .q     (q[b]),
      .q_n   (q_n[b])
    );
  end

  assign bo_n = ~(down_n & (&q_n));
  assign co_n = ~(up_n & q[0] & q[3]);

endmodule

`default_nettype wire

/* source/sn7447.sv */
`default_nettype none

module sn7447 (
  input  ttl_pkg::bcd_t digit,
  input  logic          lt_n,     // lamp test, all segments on
  input  logic          rbi_n,    // blank this digit when it is 0
  output ttl_pkg::seg_t seg,      // active low, a to g
  output logic          rbo_n     // low when this digit is blanked
);
  import ttl_pkg::*;

  seg_t glyph;                    // pattern before lamp test and blanking
  logic blank;

  // segment order abcdefg, 0 lights the segment
  always_comb begin
    case (digit)
      4'd0:  glyph = 7'b0000001;
      4'd1:  glyph = 7'b1001111;
      4'd2:  glyph = 7'b0010010;
      4'd3:  glyph = 7'b0000110;
      4'd4:  glyph = 7'b1001100;
      4'd5:  glyph = 7'b0100100;
      4'd6:  glyph = 7'b1100000;  // no top bar on this part
      4'd7:  glyph = 7'b0001111;
      4'd8:  glyph = 7'b0000000;
      4'd9:  glyph = 7'b0001100;  // no tail
      // codes above 9 give the odd shapes of the real decoder
      4'd10: glyph = 7'b1110010;
      4'd11: glyph = 7'b1100110;
      4'd12: glyph = 7'b1011100;
      4'd13: glyph = 7'b0110100;
      4'd14: glyph = 7'b1110000;
      4'd15: glyph = 7'b1111111;  // dark
    endcase
  end

  // lamp test overrides ripple blanking, as on the chip
  assign blank = lt_n & ~rbi_n & (digit == 4'd0);
  assign rbo_n = ~blank;

  always_comb begin
    if (!lt_n) begin
      seg = '0;
    end else if (blank) begin
      seg = '1;
    end else begin
      seg = glyph;
    end
  end

endmodule

`default_nettype wire

/* source/toggle_ff.sv */
`default_nettype none

module toggle_ff (
  input  logic CLK_DRV,
  input  logic rst_n,
  input  logic clk_n,   // chip clock, sampled as data
  input  logic pre_n,   // level preset
  input  logic clr_n,   // level clear, beats preset
  output logic q,
  output logic q_n
);

  logic clk_n_q;        // clk_n one sample back
  logic fall;           // clk_n went high to low

  assign fall = clk_n_q & ~clk_n;

  // history starts at the idle level of the chip clock
  // so leaving reset never looks like a clock edge
  always_ff @(posedge CLK_DRV) begin
    if (!rst_n) begin
      clk_n_q <= 1'b0;
    end else begin
      clk_n_q <= clk_n;
    end
  end

  always_ff @(posedge CLK_DRV) begin
    if (!rst_n) begin
      q <= 1'b0;
    end else if (!clr_n) begin
      q <= 1'b0;
    end else if (!pre_n) begin
      q <= 1'b1;
    end else if (fall) begin
      q <= ~q;          // one count step
    end
  end

  assign q_n = ~q;

endmodule

`default_nettype wire

/* source/ttl_pkg.sv */
`default_nettype none

`include "ttl_params.svh"

package ttl_pkg;

  // one decade digit, values 0 to 9 in normal use
  typedef logic [3:0] bcd_t;

  // active low segments, a in bit 6 down to g in bit 0
  typedef logic [6:0] seg_t;

  // whole count, index 0 is the units digit
  typedef bcd_t [`NUM_DIGITS-1:0] digit_array_t;

endpackage

`default_nettype wire

/* tests/counter_display_props.sv */
`default_nettype none

`include "ttl_params.svh"

module counter_display_props (
  input logic                  CLK_DRV,
  input logic                  rst_n,
  input logic                  clr,
  input ttl_pkg::digit_array_t count,
  input logic                  bo_n,
  input logic                  co_n
);
  import ttl_pkg::*;

  int unsigned fail_count = 0;  // failed assertions so far
  logic        digits_ok;       // every digit a legal BCD value
  logic        all_nines;       // count at the top of its range

  always_comb begin
    digits_ok = 1'b1;
    all_nines = 1'b1;
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      if (count[i] > 4'd9) begin
        digits_ok = 1'b0;
      end
      if (count[i] != 4'd9) begin
        all_nines = 1'b0;
      end
    end
  end

  a_digit_range: assert property (@(posedge CLK_DRV) disable iff (!rst_n) digits_ok)
    else begin
      fail_count++;
      $error("a digit of count is above 9");
    end

  // carry leaves the top digit only at all nines and borrow only at zero
  // so the two are never low together
  a_carry_borrow: assert property (@(posedge CLK_DRV) disable iff (!rst_n)
    (co_n || all_nines) && (bo_n || count == '0))
    else begin
      fail_count++;
      $error("bo_n or co_n is low away from the end of the count range");
    end

  a_clear: assert property (@(posedge CLK_DRV) disable iff (!rst_n)
    clr |=> (count == '0))
    else begin
      fail_count++;
      $error("count is not zero one cycle after clr");
    end

endmodule

bind counter_display counter_display_props i_props (
  .CLK_DRV,
  .rst_n,
  .clr,
  .count,
  .bo_n,
  .co_n
);

`default_nettype wire

/* tests/counter_display_tb.sv */
`default_nettype none

`include "ttl_params.svh"

module counter_display_tb;
  import ttl_pkg::*;

  localparam int NUM_OPS   = 200;
  localparam int OP_CYCLES = 2 * `MIN_PULSE + 4;
  localparam int RUN_LIMIT = (NUM_OPS + 8) * OP_CYCLES * 10 + 2000;

  logic                     CLK_DRV = 1'b0;
  logic                     rst_n;
  logic                     up;
  logic                     down;
  logic                     clr;
  logic                     load_n;
  logic                     lt_n;
  logic [4*`NUM_DIGITS-1:0] data;
  logic [4*`NUM_DIGITS-1:0] count;
  logic [7*`NUM_DIGITS-1:0] seg;
  logic                     bo_n;
  logic                     co_n;

  int          modulus;      // 10 to the number of digits
  int          model;        // expected count
  int unsigned lcg_state;

  counter_display i_counter_display (
    .CLK_DRV, .rst_n, .up, .down, .clr, .load_n, .lt_n,
    .data, .count, .seg, .bo_n, .co_n
  );

  always #5 CLK_DRV = ~CLK_DRV;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;  // low bits of an LCG repeat quickly
  endfunction

  function automatic int pow10(input int n);
    int p;
    p = 1;
    for (int i = 0; i < n; i++) begin
      p = p * 10;
    end
    return p;
  endfunction

  function automatic logic [4*`NUM_DIGITS-1:0] to_bcd(input int value);
    logic [4*`NUM_DIGITS-1:0] b;
    int                       rest;
    rest = value;
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      b[4*i +: 4] = 4'(rest % 10);
      rest = rest / 10;
    end
    return b;
  endfunction

  // active low SN7447 patterns in abcdefg order
  function automatic seg_t digit_glyph(input int d);
    case (d)
      0:       return 7'b0000001;
      1:       return 7'b1001111;
      2:       return 7'b0010010;
      3:       return 7'b0000110;
      4:       return 7'b1001100;
      5:       return 7'b0100100;
      6:       return 7'b1100000;
      7:       return 7'b0001111;
      8:       return 7'b0000000;
      default: return 7'b0001100;
    endcase
  endfunction

  function automatic logic [7*`NUM_DIGITS-1:0] expected_seg(input int value, input bit lamp_on);
    logic [7*`NUM_DIGITS-1:0] s;
    int                       rest;
    int                       scale;
    rest  = value;
    scale = 1;
    for (int i = 0; i < `NUM_DIGITS; i++) begin
      if (lamp_on) begin
        s[7*i +: 7] = '0;
      end else if (i > 0 && value < scale) begin
        s[7*i +: 7] = '1;  // leading zero
      end else begin
        s[7*i +: 7] = digit_glyph(rest % 10);
      end
      rest  = rest / 10;
      scale = scale * 10;
    end
    return s;
  endfunction

  // random value, or one next to a carry boundary such as 99 or 100
  function automatic int pick_load_value();
    int unsigned r;
    r = lcg_next();
    if (r[0]) begin
      return int'((r >> 1) % modulus);
    end else begin
      return (pow10(int'((r >> 1) % `NUM_DIGITS) + 1) - int'(r[5])) % modulus;
    end
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    check_equal("count", 64'(count), 64'(to_bcd(model)));
    check_equal("seg", 64'(seg), 64'(expected_seg(model, 1'b0)));
    check_equal("bo_n", 64'(bo_n), 64'd1);
    check_equal("co_n", 64'(co_n), 64'd1);
  endtask

  task automatic settle_and_check();
    repeat (`MIN_PULSE + 2) @(posedge CLK_DRV);
    @(negedge CLK_DRV);
    check_outputs();
  endtask

  task automatic step_count(input bit count_up);
    @(posedge CLK_DRV);
    if (count_up) begin
      up <= 1'b0;
    end else begin
      down <= 1'b0;
    end
    repeat (`MIN_PULSE - 1) @(posedge CLK_DRV);
    @(negedge CLK_DRV);
    // carry and borrow show while the pulse is low
    check_equal("co_n", 64'(co_n), 64'(!(count_up && model == modulus - 1)));
    check_equal("bo_n", 64'(bo_n), 64'(!(!count_up && model == 0)));
    @(posedge CLK_DRV);
    up   <= 1'b1;
    down <= 1'b1;
    if (count_up) begin
      model = (model + 1) % modulus;
    end else begin
      model = (model + modulus - 1) % modulus;
    end
    settle_and_check();
  endtask

  task automatic load_value(input int value);
    @(posedge CLK_DRV);
    data   <= to_bcd(value);
    load_n <= 1'b0;
    repeat (`MIN_PULSE) @(posedge CLK_DRV);
    load_n <= 1'b1;
    model = value;
    settle_and_check();
  endtask

  task automatic clear_count(input bit with_load, input int value);
    @(posedge CLK_DRV);
    clr <= 1'b1;
    if (with_load) begin
      data   <= to_bcd(value);  // clr must win
      load_n <= 1'b0;
    end
    repeat (`MIN_PULSE) @(posedge CLK_DRV);
    clr    <= 1'b0;
    load_n <= 1'b1;
    model = 0;
    settle_and_check();
  endtask

  task automatic lamp_test();
    @(posedge CLK_DRV);
    lt_n <= 1'b0;
    repeat (`MIN_PULSE - 1) @(posedge CLK_DRV);
    @(negedge CLK_DRV);
    check_equal("seg", 64'(seg), 64'(expected_seg(model, 1'b1)));
    check_equal("count", 64'(count), 64'(to_bcd(model)));
    @(posedge CLK_DRV);
    lt_n <= 1'b1;
    settle_and_check();
  endtask

  task automatic random_op();
    int unsigned pick;
    int          value;
    pick  = lcg_next() % 8;
    value = pick_load_value();
    case (pick)
      0, 1, 2: step_count(1'b1);
      3, 4:    step_count(1'b0);
      5:       load_value(value);
      6:       clear_count(lcg_next() % 2 == 1, value);
      default: lamp_test();
    endcase
  endtask

  // a failed bound assertion ends the run at once
  always @(negedge CLK_DRV) begin
    if (i_counter_display.i_props.fail_count != 0) begin
      $display("a bound assertion failed, see the error above");
      $display("TEST RESULT: FAIL");
      $fatal(1, "bound assertion failed");
    end
  end

  initial begin
    rst_n     = 1'b0;
    up        = 1'b1;  // chip clocks idle high
    down      = 1'b1;
    clr       = 1'b0;
    load_n    = 1'b1;
    lt_n      = 1'b1;
    data      = '0;
    modulus   = pow10(`NUM_DIGITS);
    model     = 0;
    lcg_state = 32'hf5f9;
    repeat (8) @(posedge CLK_DRV);
    rst_n <= 1'b1;
    settle_and_check();
    load_value(modulus - 1);
    step_count(1'b1);  // all nines wrap to zero
    step_count(1'b0);  // and back
    clear_count(1'b1, 5);
    lamp_test();
    for (int n = 0; n < NUM_OPS; n++) begin
      random_op();
    end
    @(negedge CLK_DRV);
    if (i_counter_display.i_props.fail_count != 0) begin
      $display("%0d concurrent assertion failures", i_counter_display.i_props.fail_count);
      $display("TEST RESULT: FAIL");
      $fatal(1, "bound assertions failed");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  initial begin
    #(RUN_LIMIT);
    $display("watchdog expired: stimulus did not finish within %0d time units", RUN_LIMIT);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation timeout");
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/ttl_pkg.sv
source/toggle_ff.sv
source/sn74192.sv
source/sn7447.sv
source/counter_display.sv
tests/counter_display_props.sv
tests/counter_display_tb.sv
